/* source/cam_pkg.sv */
`default_nettype none

package cam_pkg;

  // Quarter of an SCL bit; hardware uses 100 MHz / (4 * 100 kHz)
  localparam int CLKS_PER_QUARTER = 4;
  localparam int QTR_CNT_W = $clog2(CLKS_PER_QUARTER + 1);

  // Wait after camera reset release and for each delay marker
  localparam int DELAY_TICKS = 200;
  localparam int DELAY_CNT_W = $clog2(DELAY_TICKS + 1);

  localparam int CMD_COUNT = 12;
  localparam int CMD_ADDR_W = $clog2(CMD_COUNT);

  localparam logic [7:0] SCCB_DEV_WRITE = 8'h42;
  localparam logic [15:0] DELAY_MARKER = 16'hFFF0;

  // One table entry, register address in the upper byte
  typedef struct packed {
    logic [7:0] reg_addr;
    logic [7:0] reg_data;
  } sccb_cmd_t;

  typedef enum logic [2:0] {
    CAM_RESET,
    CAM_POWERUP,
    CAM_FETCH,
    CAM_DECODE,
    CAM_SEND,
    CAM_WAIT,
    CAM_DONE
  } cam_state_t;

  typedef enum logic [2:0] {
    SCCB_IDLE,
    SCCB_START,
    SCCB_BYTE,
    SCCB_ACK,
    SCCB_STOP
  } sccb_phase_t;

endpackage

`default_nettype wire

/* source/cam_cmd_rom.sv */
`default_nettype none

module cam_cmd_rom (
  input  wire logic                      clk,
  input  wire logic [cam_pkg::CMD_ADDR_W-1:0] rom_addr,
  output logic [15:0]                    rom_data
);
  import cam_pkg::*;

  logic [15:0] rom_mem [CMD_COUNT];

  // Register table, one write or delay marker per word
  initial begin
    $readmemh("source/cam_init.hex", rom_mem);
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    rom_data <= rom_mem[rom_addr];
  end

endmodule

`default_nettype wire

/* source/delay_timer.sv */
`default_nettype none

module delay_timer (
  input  wire logic clk,
  input  wire logic arst_n,
  input  wire logic delay_start,
  output logic      delay_done
);
  import cam_pkg::*;

  logic [DELAY_CNT_W-1:0] count;

  // Count runs from DELAY_TICKS-1 down to 1, done lands DELAY_TICKS cycles after start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count      <= '0;
      delay_done <= 1'b0;
    end else begin
      delay_done <= 1'b0;
      if (delay_start) begin
        count <= DELAY_CNT_W'(DELAY_TICKS - 1);
      end else if (count != '0) begin
        count <= count - 1'b1;
        if (count == DELAY_CNT_W'(1)) begin
          delay_done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/sccb_master.sv */
`default_nettype none

module sccb_master (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               wr_start,
  input  wire cam_pkg::sccb_cmd_t wr_cmd,
  output logic                    busy,
  output logic                    wr_done,
  output logic                    nack,
  output logic                    scl,
  inout  wire                     sda
);
  import cam_pkg::*;

  sccb_phase_t          phase;
  logic [QTR_CNT_W-1:0] qcnt;
  logic [1:0]           quarter;
  logic [2:0]           bit_idx;
  logic [1:0]           byte_idx;
  logic [7:0]           shift;
  sccb_cmd_t            cmd_q;
  logic                 sda_low;
  logic                 tick;

  assign tick = (qcnt == QTR_CNT_W'(CLKS_PER_QUARTER - 1));
  assign busy = (phase != SCCB_IDLE);

  // Open drain, the line is pulled up outside
  assign sda = sda_low ? 1'b0 : 1'bz;

  // Quarter-bit divider, only runs during a transaction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      qcnt <= '0;
    end else if (phase == SCCB_IDLE || tick) begin
      qcnt <= '0;
    end else begin
      qcnt <= qcnt + 1'b1;
    end
  end

  // Each bit is four quarters: SCL low, low with new data, high, high
  // Actions below fire at the end of the current quarter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase    <= SCCB_IDLE;
      quarter  <= '0;
      bit_idx  <= '0;
      byte_idx <= '0;
      shift    <= '0;
      cmd_q    <= '0;
      sda_low  <= 1'b0;
      scl      <= 1'b1;
      nack     <= 1'b0;
      wr_done  <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      if (phase == SCCB_IDLE) begin
        if (wr_start) begin
          phase    <= SCCB_START;
          quarter  <= '0;
          bit_idx  <= 3'd7;
          byte_idx <= '0;
          shift    <= SCCB_DEV_WRITE;
          cmd_q    <= wr_cmd;
          nack     <= 1'b0;
        end
      end else if (tick) begin
        quarter <= quarter + 1'b1;
        case (phase)
          SCCB_START: begin
            // SDA falls halfway through with SCL still high
            if (quarter == 2'd1) begin
              sda_low <= 1'b1;
            end
            if (quarter == 2'd3) begin
              scl   <= 1'b0;
              phase <= SCCB_BYTE;
            end
          end
          SCCB_BYTE: begin
            case (quarter)
              2'd0: sda_low <= ~shift[7];
              2'd1: scl <= 1'b1;
              2'd3: begin
                scl   <= 1'b0;
                shift <= {shift[6:0], 1'b0};
                if (bit_idx == '0) begin
                  phase <= SCCB_ACK;
                end else begin
                  bit_idx <= bit_idx - 1'b1;
                end
              end
              default: ;
            endcase
          end
          SCCB_ACK: begin
            case (quarter)
              2'd0: sda_low <= 1'b0;
              2'd1: scl <= 1'b1;
              // Middle of SCL high, a released line means NACK
              2'd2: nack <= nack | sda;
              2'd3: begin
                scl <= 1'b0;
                if (byte_idx == 2'd2) begin
                  phase <= SCCB_STOP;
                end else begin
                  byte_idx <= byte_idx + 1'b1;
                  bit_idx  <= 3'd7;
                  shift    <= (byte_idx == 2'd0) ? cmd_q.reg_addr : cmd_q.reg_data;
                  phase    <= SCCB_BYTE;
                end
              end
              default: ;
            endcase
          end
          SCCB_STOP: begin
            case (quarter)
              2'd0: sda_low <= 1'b1;
              2'd1: scl <= 1'b1;
              // SDA rises while SCL is high
              2'd2: sda_low <= 1'b0;
              2'd3: begin
                phase   <= SCCB_IDLE;
                wr_done <= 1'b1;
              end
              default: ;
            endcase
          end
          default: phase <= SCCB_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* source/cam_init_seq.sv */
`default_nettype none

module cam_init_seq (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         start,
  input  wire logic [15:0]                  rom_data,
  output logic [cam_pkg::CMD_ADDR_W-1:0]    rom_addr,
  output logic                              delay_start,
  input  wire logic                         delay_done,
  output logic                              wr_start,
  output cam_pkg::sccb_cmd_t                wr_cmd,
  input  wire logic                         busy,
  input  wire logic                         wr_done,
  input  wire logic                         nack,
  output logic                              cam_rst_n,
  output cam_pkg::cam_state_t               state,
  output logic                              done,
  output logic                              err
);
  import cam_pkg::*;

  logic last_entry;
  logic step_done;

  assign last_entry = (rom_addr == CMD_ADDR_W'(CMD_COUNT - 1));

  // Only one of the two is ever pending in CAM_WAIT
  assign step_done = delay_done || wr_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= CAM_RESET;
      rom_addr    <= '0;
      delay_start <= 1'b0;
      wr_start    <= 1'b0;
      cam_rst_n   <= 1'b0;
      done        <= 1'b0;
      err         <= 1'b0;
    end else begin
      delay_start <= 1'b0;
      wr_start    <= 1'b0;
      case (state)
        CAM_RESET: begin
          if (start) begin
            cam_rst_n   <= 1'b1;
            delay_start <= 1'b1;
            state       <= CAM_POWERUP;
          end
        end
        CAM_POWERUP: begin
          if (delay_done) begin
            state <= CAM_FETCH;
          end
        end
        // ROM answers in the next cycle
        CAM_FETCH: begin
          state <= CAM_DECODE;
        end
        CAM_DECODE: begin
          if (rom_data == DELAY_MARKER) begin
            delay_start <= 1'b1;
            state       <= CAM_WAIT;
          end else begin
            state <= CAM_SEND;
          end
        end
        CAM_SEND: begin
          if (!busy) begin
            wr_start <= 1'b1;
            state    <= CAM_WAIT;
          end
        end
        CAM_WAIT: begin
          if (step_done) begin
            if (wr_done && nack) begin
              err <= 1'b1;
            end
            if (last_entry) begin
              done  <= 1'b1;
              state <= CAM_DONE;
            end else begin
              rom_addr <= rom_addr + 1'b1;
              state    <= CAM_FETCH;
            end
          end
        end
        // Terminal until the next reset, start is ignored here
        CAM_DONE: begin
          done <= 1'b1;
        end
        default: begin
          state <= CAM_RESET;
        end
      endcase
    end
  end

  // Write payload, captured while the entry is decoded
  always_ff @(posedge clk) begin
    if (state == CAM_DECODE) begin
      wr_cmd <= sccb_cmd_t'(rom_data);
    end
  end

endmodule

`default_nettype wire

/* source/cam_ctrl_top.sv */
`default_nettype none

module cam_ctrl_top (
  input  wire logic            clk,
  input  wire logic            arst_n,
  input  wire logic            start,
  output logic                 scl,
  inout  wire                  sda,
  output logic                 cam_rst_n,
  output cam_pkg::cam_state_t  state,
  output logic                 done,
  output logic                 err
);
  import cam_pkg::*;

  logic [CMD_ADDR_W-1:0] rom_addr;
  logic [15:0]           rom_data;
  logic                  delay_start;
  logic                  delay_done;
  logic                  wr_start;
  sccb_cmd_t             wr_cmd;
  logic                  busy;
  logic                  wr_done;
  logic                  nack;

  cam_cmd_rom cam_cmd_rom_inst (
    .clk      (clk),
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  delay_timer delay_timer_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .delay_start (delay_start),
    .delay_done  (delay_done)
  );

  sccb_master sccb_master_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_start (wr_start),
    .wr_cmd   (wr_cmd),
    .busy     (busy),
    .wr_done  (wr_done),
    .nack     (nack),
    .scl      (scl),
    .sda      (sda)
  );

  cam_init_seq cam_init_seq_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .rom_data    (rom_data),
    .rom_addr    (rom_addr),
    .delay_start (delay_start),
    .delay_done  (delay_done),
    .wr_start    (wr_start),
    .wr_cmd      (wr_cmd),
    .busy        (busy),
    .wr_done     (wr_done),
    .nack        (nack),
    .cam_rst_n   (cam_rst_n),
    .state       (state),
    .done        (done),
    .err         (err)
  );

endmodule

`default_nettype wire

/* tests/sccb_slave_model.sv */
`default_nettype none

module sccb_slave_model (
  input  wire logic       scl,
  inout  wire             sda,
  input  wire logic [7:0] nack_index
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LOG_DEPTH = 32;

  logic [7:0] log_dev [LOG_DEPTH];
  logic [7:0] log_reg [LOG_DEPTH];
  logic [7:0] log_data [LOG_DEPTH];
  realtime    start_times [LOG_DEPTH];
  realtime    stop_times [LOG_DEPTH];
  int         log_count;
  int         start_count;
  int         stop_count;

  logic       active;
  logic       in_ack;
  logic       ack_low;
  logic [7:0] shreg;
  logic [7:0] frame [3];
  int         bit_cnt;
  int         byte_cnt;

  assign sda = ack_low ? 1'b0 : 1'bz;

  task automatic clear_log();
    log_count   = 0;
    start_count = 0;
    stop_count  = 0;
  endtask

  initial begin
    active   = 1'b0;
    in_ack   = 1'b0;
    ack_low  = 1'b0;
    shreg    = '0;
    bit_cnt  = 0;
    byte_cnt = 0;
    clear_log();
  end

  // Start condition, SDA falls while SCL is high
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      if (start_count < LOG_DEPTH) begin
        start_times[start_count] = $realtime;
      end
      start_count = start_count + 1;
      active      = 1'b1;
      in_ack      = 1'b0;
      bit_cnt     = 0;
      byte_cnt    = 0;
    end
  end

  // Stop condition, a write is logged only with all three bytes
  always @(posedge sda) begin
    if (scl === 1'b1 && active) begin
      if (stop_count < LOG_DEPTH) begin
        stop_times[stop_count] = $realtime;
      end
      stop_count = stop_count + 1;
      active     = 1'b0;
      if (byte_cnt == 3 && log_count < LOG_DEPTH) begin
        log_dev[log_count]  = frame[0];
        log_reg[log_count]  = frame[1];
        log_data[log_count] = frame[2];
        log_count = log_count + 1;
      end
    end
  end

  always @(posedge scl) begin
    if (active && !in_ack && bit_cnt < 8 && byte_cnt < 3) begin
      shreg   = {shreg[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
      bit_cnt = bit_cnt + 1;
    end
  end

  always @(negedge scl) begin
    if (active) begin
      if (in_ack) begin
        ack_low  = 1'b0;
        in_ack   = 1'b0;
        bit_cnt  = 0;
        byte_cnt = byte_cnt + 1;
      end else if (bit_cnt == 8 && byte_cnt < 3) begin
        frame[byte_cnt] = shreg;
        in_ack          = 1'b1;
        // Register byte of the selected write is left unacknowledged
        ack_low = !(byte_cnt == 1 && log_count == int'(nack_index));
      end
    end
  end

endmodule

`default_nettype wire

/* tests/cam_ctrl_tb.sv */
`default_nettype none

module cam_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import cam_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int WRITE_CYCLES = 29 * 4 * CLKS_PER_QUARTER;
  localparam int TIMEOUT_CYCLES = 2 * (CMD_COUNT * WRITE_CYCLES + 2 * DELAY_TICKS) + 1000;
  localparam int NACK_WRITE = 3;

  logic       clk;
  logic       arst_n;
  logic       start;
  logic       scl;
  wire        sda;
  logic       cam_rst_n;
  cam_state_t state;
  logic       done;
  logic       err;
  logic [7:0] nack_index;

  logic [15:0] table_words [CMD_COUNT];
  logic [7:0]  exp_reg [CMD_COUNT];
  logic [7:0]  exp_data [CMD_COUNT];
  int          exp_count;
  int          marker_index;
  int          writes_before_marker;
  realtime     rst_release_time;
  int          cycle_count = 0;

  cam_ctrl_top cam_ctrl_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .scl       (scl),
    .sda       (sda),
    .cam_rst_n (cam_rst_n),
    .state     (state),
    .done      (done),
    .err       (err)
  );

  pullup (sda);

  sccb_slave_model sccb_slave_model_inst (
    .scl        (scl),
    .sda        (sda),
    .nack_index (nack_index)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic compare_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0d ns: %s expected 8'h%h, got 8'h%h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic compare_state(input string name, input cam_state_t expected,
                               input cam_state_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0d ns: %s expected %s, got %s",
                         $time, name, expected.name(), actual.name()));
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0d ns: %s expected %b, got %b",
                         $time, name, expected, actual));
    end
  endtask

  // Expected writes come straight from the table with markers skipped
  task automatic load_expected();
    int i;
    exp_count = 0;
    marker_index = -1;
    writes_before_marker = 0;
    $readmemh("source/cam_init.hex", table_words);
    for (i = 0; i < CMD_COUNT; i++) begin
      if ($isunknown(table_words[i])) begin
        fail_run("The register table file holds fewer entries than the ROM");
      end
      if (table_words[i] === DELAY_MARKER) begin
        if (marker_index < 0) begin
          marker_index = i;
          writes_before_marker = exp_count;
        end
      end else begin
        exp_reg[exp_count]  = table_words[i][15:8];
        exp_data[exp_count] = table_words[i][7:0];
        exp_count++;
      end
    end
    if (marker_index < 0 || writes_before_marker == 0 || writes_before_marker == exp_count) begin
      fail_run("The register table has no delay marker between two writes");
    end
  endtask

  task automatic check_idle_outputs();
    compare_bit("cam_rst_n", 1'b0, cam_rst_n);
    compare_bit("scl", 1'b1, scl);
    compare_bit("sda", 1'b1, sda);
    compare_bit("done", 1'b0, done);
    compare_bit("err", 1'b0, err);
    compare_state("state", CAM_RESET, state);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    start  <= 1'b0;
    repeat (16) @(posedge clk);
    check_idle_outputs();
    arst_n <= 1'b1;
    // Let the DUT run a clock edge out of reset with start low
    repeat (2) @(posedge clk);
    check_idle_outputs();
    sccb_slave_model_inst.clear_log();
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_for_done();
    while (done !== 1'b1) begin
      @(posedge clk);
    end
  endtask

  task automatic check_write_log();
    int i;
    if (sccb_slave_model_inst.log_count != exp_count) begin
      fail_run($sformatf("Error at %0d ns: write count expected %0d, got %0d",
                         $time, exp_count, sccb_slave_model_inst.log_count));
    end
    for (i = 0; i < exp_count; i++) begin
      compare_byte($sformatf("device of write %0d", i), 8'h42,
                   sccb_slave_model_inst.log_dev[i]);
      compare_byte($sformatf("register of write %0d", i), exp_reg[i],
                   sccb_slave_model_inst.log_reg[i]);
      compare_byte($sformatf("data of write %0d", i), exp_data[i],
                   sccb_slave_model_inst.log_data[i]);
    end
  endtask

  task automatic test_reset_state();
    nack_index <= 8'hFF;
    apply_reset();
  endtask

  task automatic test_power_up_delay();
    int      wait_cycles;
    realtime gap;
    pulse_start();
    wait_cycles = 0;
    while (cam_rst_n !== 1'b1) begin
      if (wait_cycles == 4) begin
        fail_run("Camera reset was not released after the start pulse");
      end
      @(posedge clk);
      wait_cycles++;
    end
    // The registered output changed at the previous edge
    rst_release_time = $realtime - CLK_PERIOD;
    while (sccb_slave_model_inst.start_count == 0) begin
      @(posedge clk);
    end
    gap = sccb_slave_model_inst.start_times[0] - rst_release_time;
    if (gap < DELAY_TICKS * CLK_PERIOD) begin
      fail_run($sformatf("First SCCB start came only %0.1f ns after camera reset release", gap));
    end
  endtask

  task automatic test_full_table();
    wait_for_done();
    check_write_log();
    compare_state("state", CAM_DONE, state);
    compare_bit("err", 1'b0, err);
  endtask

  // Gap from the stop before the marker to the start after it
  task automatic test_delay_marker();
    realtime gap;
    gap = sccb_slave_model_inst.start_times[writes_before_marker]
        - sccb_slave_model_inst.stop_times[writes_before_marker - 1];
    if (gap < DELAY_TICKS * CLK_PERIOD) begin
      fail_run($sformatf("Writes around the delay marker were only %0.1f ns apart", gap));
    end
  endtask

  task automatic test_start_after_done();
    int starts_before;
    int i;
    starts_before = sccb_slave_model_inst.start_count;
    pulse_start();
    for (i = 0; i < WRITE_CYCLES; i++) begin
      @(posedge clk);
      compare_bit("done", 1'b1, done);
    end
    if (sccb_slave_model_inst.start_count != starts_before) begin
      fail_run("A start pulse after done began a new SCCB transaction");
    end
    compare_state("state", CAM_DONE, state);
  endtask

  task automatic test_nack();
    nack_index <= 8'(NACK_WRITE);
    apply_reset();
    pulse_start();
    while (err !== 1'b1) begin
      if (done === 1'b1) begin
        fail_run("The controller finished without raising err for the NACKed write");
      end
      @(posedge clk);
    end
    // Err is sticky until the next reset
    while (done !== 1'b1) begin
      compare_bit("err", 1'b1, err);
      @(posedge clk);
    end
    compare_bit("err", 1'b1, err);
    compare_state("state", CAM_DONE, state);
    check_write_log();
  endtask

  initial begin
    arst_n     = 1'b0;
    start      = 1'b0;
    nack_index = 8'hFF;
    load_expected();
    test_reset_state();
    test_power_up_delay();
    test_full_table();
    test_delay_marker();
    test_start_after_done();
    test_nack();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
source/cam_pkg.sv
source/cam_cmd_rom.sv
source/delay_timer.sv
source/sccb_master.sv
source/cam_init_seq.sv
source/cam_ctrl_top.sv
tests/sccb_slave_model.sv
tests/cam_ctrl_tb.sv

/* source/cam_init.hex */
// One 16-bit word per line: register address in the upper byte, data in the lower byte
// FFF0 is the delay marker, the controller waits instead of writing
1280
FFF0
1204
8C00
40D0
3A04
1438
4F40
5034
510C
5217
5329
